/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_accel_controller -f tb.f -o tb_accel_controller \
    && ./obj_dir/tb_accel_controller > sim.log 2>&1
cat sim.log 2>/dev/null
[ -f sim.log ] && ! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

/* sim/tb_accel_controller.sv */
`default_nettype none

`include "ctrl_defines.svh"

module tb_accel_controller
    import ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST = 12;
    localparam int TIMEOUT_CYCLES = 400 * (N_INST + 2);

    logic                       clk;
    logic                       n_reset;
    logic                       start;
    inst_t                      inst;
    logic                       inst_valid;
    logic                       inst_next;
    logic                       done;
    logic [`DDR_ADDR_WIDTH-1:0] ddr_addr;
    logic                       ddr_read_en;
    logic [`DDR_LEN_WIDTH-1:0]  ddr_len;
    logic [`DDR_DATA_WIDTH-1:0] ddr_data;
    logic                       ddr_valid;
    logic [`BUF_ADDR_WIDTH-1:0] buf_addr;
    logic [`DDR_DATA_WIDTH-1:0] buf_data;
    logic                       buf_inst_en;
    logic                       buf_bias_en;
    logic                       buf_tail_en;
    logic                       buf_rank_en;
    conv_fields_t               conv_params;
    pool_fields_t               pool_params;
    concat_fields_t             concat_params;
    upsample_fields_t           upsample_params;
    logic                       conv_start;
    logic                       pool_start;
    logic                       concat_start;
    logic                       upsample_start;
    logic                       conv_reset;
    logic                       pool_reset;
    logic                       concat_reset;
    logic                       upsample_reset;
    logic                       conv_done;
    logic                       pool_done;
    logic                       concat_done;
    logic                       upsample_done;

    logic [3:0]  eng_done;
    logic [3:0]  eng_starts;
    logic [3:0]  eng_resets;
    logic [3:0]  buf_ens;
    logic [14:0] ctrl_outs;

    inst_t        prog [N_INST];
    op_e          ops [N_INST];
    int           src_idx;
    int           errors;
    logic         started;

    // scoreboard state
    inst_t              cur;
    load_fields_t       lf;
    logic               busy;
    logic               boot_expect;
    logic               ld_boot;
    logic               last_write;
    logic               exp_next;
    logic [31:0]        exp_addr;
    logic [7:0]         exp_len;
    logic [2:0]         exp_id;
    logic [31:0]        ld_addr;
    logic [15:0]        ld_len;
    logic [2:0]         ld_id;
    logic [15:0]        wr_count;
    int                 rst_pulses;
    int                 n_starts;
    int                 n_loads;
    int                 n_boot;
    int                 n_next;
    int                 n_compute;

    assign conv_done     = eng_done[0];
    assign pool_done     = eng_done[1];
    assign concat_done   = eng_done[2];
    assign upsample_done = eng_done[3];
    assign eng_starts = {upsample_start, concat_start, pool_start, conv_start};
    assign eng_resets = {upsample_reset, concat_reset, pool_reset, conv_reset};
    assign buf_ens    = {buf_rank_en, buf_tail_en, buf_bias_en, buf_inst_en};
    assign ctrl_outs  = {eng_starts, eng_resets, inst_next, done, ddr_read_en, buf_ens};

    accel_controller dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("mismatch %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    // DDR word depends on the whole address and the beat index
    function automatic logic [63:0] beat_word(input logic [31:0] addr, input logic [15:0] idx);
        return {addr ^ 32'h5a5a_c3c3, 16'hbeef, idx};
    endfunction

    function automatic logic [3:0] start_mask(input op_e op);
        case (op)
            OP_CONV:     return 4'b0001;
            OP_POOL:     return 4'b0010;
            OP_CONCAT:   return 4'b0100;
            OP_UPSAMPLE: return 4'b1000;
            default:     return 4'b0000;
        endcase
    endfunction

    // engines and DDR share one model, only one task runs at a time
    initial begin : task_responder
        int          d;
        int          len;
        int          k;
        logic [3:0]  mask;
        logic [31:0] addr;
        forever begin
            @(negedge clk);
            if (n_reset && |eng_starts) begin
                mask = eng_starts;
                d = $urandom_range(10, 1);
                repeat (d) @(posedge clk);
                #1 eng_done = mask;
                next_cycle();
                eng_done = '0;
            end else if (n_reset && ddr_read_en) begin
                addr = ddr_addr;
                len = int'(ddr_len);
                next_cycle();
                for (k = 0; k < len; k++) begin
                    repeat ($urandom_range(2, 0)) next_cycle();
                    ddr_data = beat_word(addr, 16'(k));
                    ddr_valid = 1'b1;
                    next_cycle();
                    ddr_valid = 1'b0;
                end
            end
        end
    end

    initial begin : inst_source
        forever begin
            @(negedge clk);
            if (inst_next) begin
                next_cycle();
                if (src_idx < N_INST - 1) begin
                    src_idx++;
                end
                inst = prog[src_idx];
            end
        end
    end

    always @(negedge clk) begin
        if (!n_reset) begin
            busy = 1'b0;
            boot_expect = 1'b0;
            ld_boot = 1'b0;
            ld_len = '0;
            wr_count = '0;
            rst_pulses = 0;
        end else begin
            cur = prog[src_idx];
            if (start) begin
                boot_expect = 1'b1;
                rst_pulses = 0;
            end
            if (conv_reset) begin
                rst_pulses++;
            end
            if (|eng_starts) begin
                assert (!busy) else begin
                    errors++;
                    $display("engine started while an earlier task was unfinished");
                end
                busy = 1'b1;
                n_starts++;
                check_value("engine starts", 256'(eng_starts), 256'(start_mask(cur.op)));
                if (conv_start) check_value("conv_params", 256'(conv_params), 256'(cur.payload));
                if (pool_start) check_value("pool_params", 256'(pool_params), 256'(cur.payload));
                if (concat_start) begin
                    check_value("concat_params", 256'(concat_params), 256'(cur.payload));
                end
                if (upsample_start) begin
                    check_value("upsample_params", 256'(upsample_params), 256'(cur.payload));
                end
            end
            if (ddr_read_en) begin
                assert (!busy) else begin
                    errors++;
                    $display("DDR read issued while an earlier task was unfinished");
                end
                busy = 1'b1;
                if (boot_expect) begin
                    exp_addr = `BOOT_DDR_ADDR;
                    exp_len = `BOOT_DDR_LEN;
                    exp_id = `BUFID_INST;
                    ld_boot = 1'b1;
                    boot_expect = 1'b0;
                    n_boot++;
                    check_value("engine reset pulses", 256'(rst_pulses), 256'(1));
                end else begin
                    lf = load_fields_t'(cur.payload);
                    check_value("op of loading instruction", 256'(cur.op), 256'(OP_LOAD));
                    exp_addr = lf.ddr_addr;
                    exp_len = lf.ddr_len;
                    exp_id = lf.buf_id;
                    ld_boot = 1'b0;
                    n_loads++;
                end
                check_value("ddr_addr", 256'(ddr_addr), 256'(exp_addr));
                check_value("ddr_len", 256'(ddr_len), 256'(exp_len));
                ld_addr = exp_addr;
                ld_len = 16'(exp_len);
                ld_id = exp_id;
                wr_count = '0;
            end
            last_write = 1'b0;
            if (|buf_ens) begin
                if (wr_count >= ld_len) begin
                    errors++;
                    $display("buffer write with no beat of a burst outstanding");
                end else begin
                    check_value("buffer enables", 256'(buf_ens), 256'(4'b0001 << ld_id));
                    check_value("buf_addr", 256'(buf_addr), 256'(wr_count));
                    check_value("buf_data", 256'(buf_data), 256'(beat_word(ld_addr, wr_count)));
                    wr_count++;
                    if (wr_count == ld_len) begin
                        last_write = 1'b1;
                        busy = 1'b0;
                    end
                end
            end
            if (|eng_done) begin
                busy = 1'b0;
            end
            exp_next = (|eng_done) || (last_write && !ld_boot);
            check_value("inst_next", 256'(inst_next), 256'(exp_next));
            if (inst_next) begin
                n_next++;
            end
        end
    end

    a_quiet_before_start: assert property (@(negedge clk) disable iff (!n_reset)
        !started |-> (ctrl_outs == '0)
    ) else begin
        errors++;
        $display("control outputs active before the first start");
    end

    a_resets_together: assert property (@(negedge clk) disable iff (!n_reset)
        (eng_resets == 4'b0000) || (eng_resets == 4'b1111)
    ) else begin
        errors++;
        $display("mismatch engine resets: got %h, expected 0 or f", eng_resets);
    end

    a_reset_one_cycle: assert property (@(negedge clk) disable iff (!n_reset)
        conv_reset |=> !conv_reset
    ) else begin
        errors++;
        $display("engine reset held longer than one cycle");
    end

    a_quiet_when_done: assert property (@(negedge clk) disable iff (!n_reset)
        done |-> (eng_starts == '0) && !ddr_read_en && !inst_next
    ) else begin
        errors++;
        $display("start, read or acknowledge while the program is done");
    end

    a_done_holds: assert property (@(negedge clk) disable iff (!n_reset)
        (done && !start) |=> done
    ) else begin
        errors++;
        $display("done dropped without a new start");
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: controller did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors %0d, starts %0d, loads %0d, acks %0d", errors + 1, n_starts,
                 n_loads, n_next);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        logic [255:0] raw;
        void'($urandom(32'h1ff8_5e53));
        n_reset = 1'b0;
        start = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        ddr_data = '0;
        ddr_valid = 1'b0;
        eng_done = '0;
        src_idx = 0;
        errors = 0;
        started = 1'b0;
        n_starts = 0;
        n_loads = 0;
        n_boot = 0;
        n_next = 0;
        n_compute = 0;

        ops = '{OP_CONV, OP_POOL, OP_LOAD, OP_CONCAT, OP_UPSAMPLE, OP_CONV,
                OP_LOAD, OP_POOL, OP_CONCAT, OP_UPSAMPLE, OP_CONV, OP_DONE};
        for (int i = 0; i < N_INST; i++) begin
            for (int w = 0; w < 8; w++) begin
                raw[w*32 +: 32] = $urandom;
            end
            prog[i].op = ops[i];
            prog[i].payload = raw[PAYLOAD_WIDTH-1:0];
            if (ops[i] == OP_LOAD) begin
                lf = '0;
                lf.buf_id = (n_compute < 3) ? BUF_BIAS : BUF_TAIL;
                lf.ddr_addr = $urandom;
                lf.ddr_len = (n_compute < 3) ? 8'd5 : 8'd12;
                prog[i].payload = lf;
            end else if (ops[i] != OP_DONE) begin
                n_compute++;
            end
        end

        repeat (5) @(posedge clk);
        #1 n_reset = 1'b1;
        repeat (10) next_cycle();

        inst = prog[0];
        inst_valid = 1'b1;
        started = 1'b1;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        while (!done) next_cycle();
        repeat (6) next_cycle();

        // restart with the source still on DONE
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_value("done after restart", 256'(done), 256'(0));
        while (!done) next_cycle();
        repeat (4) next_cycle();

        check_value("instruction acks", 256'(n_next), 256'(N_INST - 1));
        check_value("engine start count", 256'(n_starts), 256'(n_compute));
        check_value("program load count", 256'(n_loads), 256'(2));
        check_value("boot load count", 256'(n_boot), 256'(2));
        check_value("source index", 256'(src_idx), 256'(N_INST - 1));

        $display("errors %0d, starts %0d, loads %0d, acks %0d", errors, n_starts,
                 n_loads, n_next);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/inst_sequencer.sv
verilog/inst_decoder.sv
verilog/engine_launch.sv
verilog/buffer_loader.sv
verilog/accel_controller.sv
sim/tb_accel_controller.sv

/* verilog/accel_controller.sv */
`default_nettype none

`include "ctrl_defines.svh"

module accel_controller
    import ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       n_reset,
    input  logic                       start,
    input  inst_t                      inst,
    input  logic                       inst_valid,
    output logic                       inst_next,
    output logic                       done,

    output logic [`DDR_ADDR_WIDTH-1:0] ddr_addr,
    output logic                       ddr_read_en,
    output logic [`DDR_LEN_WIDTH-1:0]  ddr_len,
    input  logic [`DDR_DATA_WIDTH-1:0] ddr_data,
    input  logic                       ddr_valid,

    output logic [`BUF_ADDR_WIDTH-1:0] buf_addr,
    output logic [`DDR_DATA_WIDTH-1:0] buf_data,
    output logic                       buf_inst_en,
    output logic                       buf_bias_en,
    output logic                       buf_tail_en,
    output logic                       buf_rank_en,

    output conv_fields_t               conv_params,
    output logic                       conv_start,
    output logic                       conv_reset,
    input  logic                       conv_done,
    output pool_fields_t               pool_params,
    output logic                       pool_start,
    output logic                       pool_reset,
    input  logic                       pool_done,
    output concat_fields_t             concat_params,
    output logic                       concat_start,
    output logic                       concat_reset,
    input  logic                       concat_done,
    output upsample_fields_t           upsample_params,
    output logic                       upsample_start,
    output logic                       upsample_reset,
    input  logic                       upsample_done
);
    logic             accept;
    logic             boot_pending;
    logic             program_end;
    logic             eng_reset;
    logic             load_done;
    logic             conv_fire;
    logic             pool_fire;
    logic             concat_fire;
    logic             upsample_fire;
    logic             load_fire;
    conv_fields_t     conv_fields;
    pool_fields_t     pool_fields;
    concat_fields_t   concat_fields;
    upsample_fields_t upsample_fields;
    load_fields_t     load_fields;

    // one reset pulse shared by all engines
    assign conv_reset     = eng_reset;
    assign pool_reset     = eng_reset;
    assign concat_reset   = eng_reset;
    assign upsample_reset = eng_reset;

    inst_sequencer u_seq (
        .clk(clk), .n_reset(n_reset),
        .start(start), .inst_valid(inst_valid), .program_end(program_end),
        .eng_done({upsample_done, concat_done, pool_done, conv_done}),
        .load_done(load_done), .accept(accept), .boot_pending(boot_pending),
        .eng_reset(eng_reset), .inst_next(inst_next), .done(done)
    );

    inst_decoder u_dec (
        .clk(clk), .n_reset(n_reset),
        .inst(inst), .accept(accept), .boot_pending(boot_pending),
        .program_end(program_end),
        .conv_fire(conv_fire), .conv_fields(conv_fields),
        .pool_fire(pool_fire), .pool_fields(pool_fields),
        .concat_fire(concat_fire), .concat_fields(concat_fields),
        .upsample_fire(upsample_fire), .upsample_fields(upsample_fields),
        .load_fire(load_fire), .load_fields(load_fields)
    );

    engine_launch #(.fields_t(conv_fields_t)) u_conv_launch (
        .clk(clk), .n_reset(n_reset), .fire(conv_fire), .fields_in(conv_fields),
        .done(conv_done), .start(conv_start), .params(conv_params)
    );

    engine_launch #(.fields_t(pool_fields_t)) u_pool_launch (
        .clk(clk), .n_reset(n_reset), .fire(pool_fire), .fields_in(pool_fields),
        .done(pool_done), .start(pool_start), .params(pool_params)
    );

    engine_launch #(.fields_t(concat_fields_t)) u_concat_launch (
        .clk(clk), .n_reset(n_reset), .fire(concat_fire), .fields_in(concat_fields),
        .done(concat_done), .start(concat_start), .params(concat_params)
    );

    engine_launch #(.fields_t(upsample_fields_t)) u_upsample_launch (
        .clk(clk), .n_reset(n_reset), .fire(upsample_fire), .fields_in(upsample_fields),
        .done(upsample_done), .start(upsample_start), .params(upsample_params)
    );

    buffer_loader u_loader (
        .clk(clk), .n_reset(n_reset),
        .load_start(load_fire), .fields(load_fields),
        .ddr_data(ddr_data), .ddr_valid(ddr_valid),
        .ddr_addr(ddr_addr), .ddr_read_en(ddr_read_en), .ddr_len(ddr_len),
        .buf_addr(buf_addr), .buf_data(buf_data),
        .buf_inst_en(buf_inst_en), .buf_bias_en(buf_bias_en),
        .buf_tail_en(buf_tail_en), .buf_rank_en(buf_rank_en),
        .load_done(load_done)
    );

endmodule

`default_nettype wire

/* verilog/buffer_loader.sv */
`default_nettype none

`include "ctrl_defines.svh"

module buffer_loader
    import ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       n_reset,
    input  logic                       load_start,
    input  load_fields_t               fields,
    input  logic [`DDR_DATA_WIDTH-1:0] ddr_data,
    input  logic                       ddr_valid,
    output logic [`DDR_ADDR_WIDTH-1:0] ddr_addr,
    output logic                       ddr_read_en,
    output logic [`DDR_LEN_WIDTH-1:0]  ddr_len,
    output logic [`BUF_ADDR_WIDTH-1:0] buf_addr,
    output logic [`DDR_DATA_WIDTH-1:0] buf_data,
    output logic                       buf_inst_en,
    output logic                       buf_bias_en,
    output logic                       buf_tail_en,
    output logic                       buf_rank_en,
    output logic                       load_done
);
    localparam logic [`DDR_LEN_WIDTH-1:0] LAST_BEAT = 1;

    logic [`DDR_LEN_WIDTH-1:0]  remaining;
    logic [`BUF_ADDR_WIDTH-1:0] wr_ptr;
    buf_id_e                    buf_id;
    logic                       beat;

    assign beat = ddr_valid && (remaining != '0);

    always_ff @(posedge clk) begin
        if (!n_reset) begin
            ddr_read_en <= 1'b0;
            remaining   <= '0;
            buf_inst_en <= 1'b0;
            buf_bias_en <= 1'b0;
            buf_tail_en <= 1'b0;
            buf_rank_en <= 1'b0;
            load_done   <= 1'b0;
        end else begin
            ddr_read_en <= load_start;
            if (load_start) begin
                remaining <= fields.ddr_len;
            end else if (beat) begin
                remaining <= remaining - 1'b1;
            end
            // one enable per write, picked by buffer id
            buf_inst_en <= beat && (buf_id == BUF_INST);
            buf_bias_en <= beat && (buf_id == BUF_BIAS);
            buf_tail_en <= beat && (buf_id == BUF_TAIL);
            buf_rank_en <= beat && (buf_id == BUF_RANK);
            load_done   <= beat && (remaining == LAST_BEAT);
        end
    end

    always_ff @(posedge clk) begin
        if (load_start) begin
            ddr_addr <= fields.ddr_addr;
            ddr_len  <= fields.ddr_len;
            buf_id   <= fields.buf_id;
            wr_ptr   <= '0;
        end else if (beat) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (beat) begin
            buf_addr <= wr_ptr;
            buf_data <= ddr_data;
        end
    end

    // DDR side must return exactly the requested number of beats
    a_beats_expected: assert property (
        @(posedge clk) disable iff (!n_reset)
        ddr_valid |-> (remaining != '0)
    ) else $error("buffer_loader: ddr_valid with no beats outstanding");

endmodule

`default_nettype wire

/* verilog/ctrl_defines.svh */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// instruction and bus widths
`define INST_WIDTH      256
`define OP_WIDTH        3
`define DDR_ADDR_WIDTH  32
`define BUF_ADDR_WIDTH  16
`define DDR_DATA_WIDTH  64
`define DDR_LEN_WIDTH   8
`define SIZE_WIDTH      16
`define SMALL_WIDTH     4
`define BUF_ID_WIDTH    3

// opcodes
`define OPC_CONV        3'd0
`define OPC_POOL        3'd1
`define OPC_CONCAT      3'd2
`define OPC_UPSAMPLE    3'd3
`define OPC_DONE        3'd4
`define OPC_LOAD        3'd5

// on-chip buffer ids
`define BUFID_INST      3'd0
`define BUFID_BIAS      3'd1
`define BUFID_TAIL      3'd2
`define BUFID_RANK      3'd3

// start-up
`define INIT_CYCLES     7
`define BOOT_DDR_ADDR   32'h0000_0000
`define BOOT_DDR_LEN    8'd1

`endif

/* verilog/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

    localparam int PAYLOAD_WIDTH = `INST_WIDTH - `OP_WIDTH;

    typedef logic [`DDR_ADDR_WIDTH-1:0] ddr_addr_t;
    typedef logic [`BUF_ADDR_WIDTH-1:0] buf_addr_t;
    typedef logic [`SIZE_WIDTH-1:0]     size_t;
    typedef logic [`SMALL_WIDTH-1:0]    small_t;

    typedef enum logic [`OP_WIDTH-1:0] {
        OP_CONV     = `OPC_CONV,
        OP_POOL     = `OPC_POOL,
        OP_CONCAT   = `OPC_CONCAT,
        OP_UPSAMPLE = `OPC_UPSAMPLE,
        OP_DONE     = `OPC_DONE,
        OP_LOAD     = `OPC_LOAD
    } op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT,
        ST_LOAD,
        ST_RUN,
        ST_DONE
    } ctrl_state_e;

    typedef enum logic [`BUF_ID_WIDTH-1:0] {
        BUF_INST = `BUFID_INST,
        BUF_BIAS = `BUFID_BIAS,
        BUF_TAIL = `BUFID_TAIL,
        BUF_RANK = `BUFID_RANK
    } buf_id_e;

    // bits in use per payload, the rest is reserved
    localparam int CONV_USED = 3 * `DDR_ADDR_WIDTH + 3 * `BUF_ADDR_WIDTH
                             + 6 * `SIZE_WIDTH + 3 * `SMALL_WIDTH;
    localparam int POOL_USED = 2 * `DDR_ADDR_WIDTH + `SIZE_WIDTH;
    localparam int CONCAT_USED = 3 * `DDR_ADDR_WIDTH + 4 * `BUF_ADDR_WIDTH
                               + 2 * `SIZE_WIDTH;
    localparam int UPSAMPLE_USED = 2 * `DDR_ADDR_WIDTH + 2 * `SIZE_WIDTH;
    localparam int LOAD_USED = `BUF_ID_WIDTH + `DDR_ADDR_WIDTH + `DDR_LEN_WIDTH;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-CONV_USED-1:0] reserved;
        ddr_addr_t in_addr;
        ddr_addr_t weight_addr;
        ddr_addr_t out_addr;
        buf_addr_t tail_addr;
        buf_addr_t rank_addr;
        buf_addr_t bias_addr;
        size_t     channel_size_1;
        size_t     channel_size_2;
        size_t     feature_size_1;
        size_t     feature_size_2;
        size_t     feature_size_3;
        size_t     feature_size_4;
        small_t    kernel_size;
        small_t    step;
        small_t    padding;
    } conv_fields_t;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-POOL_USED-1:0] reserved;
        ddr_addr_t in_addr;
        ddr_addr_t out_addr;
        size_t     channel_size;
    } pool_fields_t;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-CONCAT_USED-1:0] reserved;
        ddr_addr_t in_addr_1;
        ddr_addr_t in_addr_2;
        buf_addr_t tail_addr_1;
        buf_addr_t tail_addr_2;
        buf_addr_t rank_addr_1;
        buf_addr_t rank_addr_2;
        ddr_addr_t out_addr;
        size_t     channel_size;
        size_t     feature_size;
    } concat_fields_t;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-UPSAMPLE_USED-1:0] reserved;
        ddr_addr_t in_addr;
        ddr_addr_t out_addr;
        size_t     channel_size;
        size_t     feature_size;
    } upsample_fields_t;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-LOAD_USED-1:0] reserved;
        buf_id_e                    buf_id;
        ddr_addr_t                  ddr_addr;
        logic [`DDR_LEN_WIDTH-1:0]  ddr_len;
    } load_fields_t;

    typedef struct packed {
        op_e                      op;
        logic [PAYLOAD_WIDTH-1:0] payload;
    } inst_t;

endpackage

`default_nettype wire

/* verilog/engine_launch.sv */
`default_nettype none

module engine_launch
    import ctrl_pkg::*;
#(
    parameter type fields_t = conv_fields_t
) (
    input  logic    clk,
    input  logic    n_reset,
    input  logic    fire,
    input  fields_t fields_in,
    input  logic    done,
    output logic    start,
    output fields_t params
);
    logic busy;

    always_ff @(posedge clk) begin
        if (!n_reset) begin
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            start <= fire;
            if (fire) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // held until the next launch of this engine
    always_ff @(posedge clk) begin
        if (fire) begin
            params <= fields_in;
        end
    end

    // the sequencer must not issue to an engine still working
    a_no_fire_busy: assert property (
        @(posedge clk) disable iff (!n_reset)
        fire |-> !busy
    ) else $error("engine_launch: fire while engine busy");

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
`default_nettype none

`include "ctrl_defines.svh"

module inst_decoder
    import ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             n_reset,
    input  inst_t            inst,
    input  logic             accept,
    input  logic             boot_pending,
    output logic             program_end,
    output logic             conv_fire,
    output conv_fields_t     conv_fields,
    output logic             pool_fire,
    output pool_fields_t     pool_fields,
    output logic             concat_fire,
    output concat_fields_t   concat_fields,
    output logic             upsample_fire,
    output upsample_fields_t upsample_fields,
    output logic             load_fire,
    output load_fields_t     load_fields
);
    load_fields_t boot_load;
    inst_t        boot_inst;
    inst_t        sel;

    // built-in boot load, one word from DDR into the instruction buffer
    always_comb begin
        boot_load         = '0;
        boot_load.buf_id  = BUF_INST;
        boot_load.ddr_addr = `BOOT_DDR_ADDR;
        boot_load.ddr_len = `BOOT_DDR_LEN;
        boot_inst.op      = OP_LOAD;
        boot_inst.payload = boot_load;
    end

    assign sel = boot_pending ? boot_inst : inst;

    assign program_end = (sel.op == OP_DONE);

    assign conv_fire     = accept && (sel.op == OP_CONV);
    assign pool_fire     = accept && (sel.op == OP_POOL);
    assign concat_fire   = accept && (sel.op == OP_CONCAT);
    assign upsample_fire = accept && (sel.op == OP_UPSAMPLE);
    assign load_fire     = accept && (sel.op == OP_LOAD);

    // same payload bits, seen through each op's layout
    assign conv_fields     = conv_fields_t'(sel.payload);
    assign pool_fields     = pool_fields_t'(sel.payload);
    assign concat_fields   = concat_fields_t'(sel.payload);
    assign upsample_fields = upsample_fields_t'(sel.payload);
    assign load_fields     = load_fields_t'(sel.payload);

    // an unknown op launches nothing and the sequencer would wait in RUN forever
    a_known_op: assert property (
        @(posedge clk) disable iff (!n_reset)
        accept |-> sel.op inside {OP_CONV, OP_POOL, OP_CONCAT, OP_UPSAMPLE, OP_DONE, OP_LOAD}
    ) else $error("inst_decoder: accepted unknown opcode %0d", sel.op);

endmodule

`default_nettype wire

/* verilog/inst_sequencer.sv */
`default_nettype none

`include "ctrl_defines.svh"

module inst_sequencer
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       n_reset,
    input  logic       start,
    input  logic       inst_valid,
    input  logic       program_end,
    input  logic [3:0] eng_done,
    input  logic       load_done,
    output logic       accept,
    output logic       boot_pending,
    output logic       eng_reset,
    output logic       inst_next,
    output logic       done
);
    localparam int CNT_WIDTH = $clog2(`INIT_CYCLES);
    localparam logic [CNT_WIDTH-1:0] INIT_LAST = CNT_WIDTH'(`INIT_CYCLES - 1);

    ctrl_state_e          state;
    logic [CNT_WIDTH-1:0] init_cnt;
    logic                 task_done;

    assign task_done = (|eng_done) || load_done;
    assign accept    = (state == ST_LOAD) && (inst_valid || boot_pending);

    // the boot load is internal, the source is not acknowledged for it
    assign inst_next = (state == ST_RUN) && task_done && !boot_pending;
    assign done      = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (!n_reset) begin
            state        <= ST_IDLE;
            init_cnt     <= '0;
            boot_pending <= 1'b0;
            eng_reset    <= 1'b0;
        end else begin
            // lands in the second init cycle
            eng_reset <= (state == ST_INIT) && (init_cnt == '0);

            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state        <= ST_INIT;
                        init_cnt     <= '0;
                        boot_pending <= 1'b1;
                    end
                end
                ST_INIT: begin
                    if (init_cnt == INIT_LAST) begin
                        state <= ST_LOAD;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                ST_LOAD: begin
                    if (accept) begin
                        state <= program_end ? ST_DONE : ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (task_done) begin
                        state        <= ST_LOAD;
                        boot_pending <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // only one task is ever in flight, so done pulses never overlap
    a_single_done: assert property (
        @(posedge clk) disable iff (!n_reset)
        $onehot0({eng_done, load_done})
    ) else $error("inst_sequencer: overlapping done pulses %b", {eng_done, load_done});

endmodule

`default_nettype wire
